//--- design/icache_pkg.sv
package icache_pkg;

    ////////////////////////////////////////////////////////////
    // Geometry
    ////////////////////////////////////////////////////////////

    // Byte address
    localparam int ADDR_WIDTH = 32;

    // One cache line, also the memory transfer size
    localparam int LINE_WIDTH = 128;

    // Byte offset inside a line
    localparam int OFFSET_WIDTH = $clog2(LINE_WIDTH / 8);

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    typedef logic [ADDR_WIDTH-1:0] addr_t;

    typedef logic [LINE_WIDTH-1:0] line_t;

    // Controller states
    typedef enum logic [1:0] {
        IDLE,
        REFILL_REQ,
        REFILL_WAIT,
        INVALIDATE
    } ctrl_state_t;

endpackage

//--- design/icache_way_ram.sv
`timescale 1ns/1ps

module icache_way_ram #(
    parameter  int WIDTH      = 32,
    parameter  int DEPTH      = 64,
    localparam int ADDR_WIDTH = $clog2(DEPTH)
) (
    input  logic                  clk,
    input  logic                  en_i,
    input  logic                  we_i,
    input  logic [ADDR_WIDTH-1:0] addr_i,
    input  logic [WIDTH-1:0]      wdata_i,
    output logic [WIDTH-1:0]      rdata_o
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Read-first is not needed, a write leaves rdata_o untouched
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

//--- design/icache_lfsr.sv
`timescale 1ns/1ps

module icache_lfsr #(
    parameter  int NWAY      = 2,
    localparam int WAY_WIDTH = (NWAY > 1) ? $clog2(NWAY) : 1
) (
    input  logic                 clk,
    input  logic                 rst,
    output logic [WAY_WIDTH-1:0] victim_o
);

    logic [15:0] lfsr_q;
    logic        feedback;

    // x^16 + x^14 + x^13 + x^11 + 1
    assign feedback = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= 16'hace1;
        end else begin
            lfsr_q <= {lfsr_q[14:0], feedback};
        end
    end

    // Single way cache always replaces way 0
    assign victim_o = (NWAY > 1) ? lfsr_q[WAY_WIDTH-1:0] : '0;

endmodule

//--- design/icache_lookup.sv
`timescale 1ns/1ps

module icache_lookup #(
    parameter  int NWAY            = 2,
    parameter  int NSET            = 64,
    localparam int IDX_WIDTH       = $clog2(NSET),
    localparam int TAG_WIDTH       = icache_pkg::ADDR_WIDTH - IDX_WIDTH
                                     - icache_pkg::OFFSET_WIDTH,
    localparam int TAG_ENTRY_WIDTH = TAG_WIDTH + 1
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  accept_i,
    input  icache_pkg::addr_t                     addr_i,
    input  logic                                  uncached_i,
    input  logic                                  refill_done_i,
    input  logic [NWAY-1:0][TAG_ENTRY_WIDTH-1:0]  tag_rdata_i,
    input  icache_pkg::line_t [NWAY-1:0]          data_rdata_i,
    input  icache_pkg::line_t                     mem_line_i,
    output logic                                  busy_o,
    output logic                                  hit_o,
    output logic                                  miss_o,
    output icache_pkg::addr_t                     req_addr_o,
    output logic                                  req_uncached_o,
    output logic                                  rvalid_o,
    output icache_pkg::line_t                     rdata_o
);

    logic                 pending_q;
    logic                 missed_q;
    icache_pkg::addr_t    req_addr_q;
    logic                 req_uncached_q;
    logic [TAG_WIDTH-1:0] req_tag;
    logic [NWAY-1:0]      way_hit;
    logic                 any_hit;

    ////////////////////////////////////////////////////////////
    // Request register
    ////////////////////////////////////////////////////////////

    // A new acceptance replaces a request answered in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q <= 1'b0;
            missed_q  <= 1'b0;
        end else if (accept_i) begin
            pending_q <= 1'b1;
            missed_q  <= 1'b0;
        end else if (hit_o || refill_done_i) begin
            pending_q <= 1'b0;
            missed_q  <= 1'b0;
        end else if (miss_o) begin
            missed_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_i) begin
            req_addr_q     <= addr_i;
            req_uncached_q <= uncached_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Tag compare
    ////////////////////////////////////////////////////////////

    assign req_tag = req_addr_q[icache_pkg::ADDR_WIDTH-1 -: TAG_WIDTH];

    // Entry layout is {valid, tag}
    always_comb begin
        for (int i = 0; i < NWAY; i++) begin
            way_hit[i] = tag_rdata_i[i][TAG_WIDTH]
                         && (tag_rdata_i[i][TAG_WIDTH-1:0] == req_tag);
        end
    end

    assign any_hit = |way_hit;

    // Uncached reads always go to memory
    assign hit_o  = pending_q & ~missed_q & ~req_uncached_q & any_hit;
    assign miss_o = pending_q & ~missed_q & (req_uncached_q | ~any_hit);
    assign busy_o = pending_q;

    assign req_addr_o     = req_addr_q;
    assign req_uncached_o = req_uncached_q;

    // Response
    assign rvalid_o = hit_o | (pending_q & refill_done_i);

    always_comb begin
        rdata_o = mem_line_i;
        for (int i = 0; i < NWAY; i++) begin
            if (hit_o && way_hit[i]) begin
                rdata_o = data_rdata_i[i];
            end
        end
    end

endmodule

//--- design/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl #(
    parameter  int NWAY            = 2,
    parameter  int NSET            = 64,
    localparam int IDX_WIDTH       = $clog2(NSET),
    localparam int TAG_WIDTH       = icache_pkg::ADDR_WIDTH - IDX_WIDTH
                                     - icache_pkg::OFFSET_WIDTH,
    localparam int TAG_ENTRY_WIDTH = TAG_WIDTH + 1,
    localparam int WAY_WIDTH       = (NWAY > 1) ? $clog2(NWAY) : 1
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_i,
    input  icache_pkg::addr_t          addr_i,
    input  logic                       invalidate_i,
    input  logic                       busy_i,
    input  logic                       hit_i,
    input  logic                       miss_i,
    input  icache_pkg::addr_t          req_addr_i,
    input  logic                       req_uncached_i,
    input  logic [WAY_WIDTH-1:0]       victim_i,
    input  logic                       mem_valid_i,
    input  icache_pkg::line_t          mem_line_i,
    output logic                       ack_o,
    output logic                       refill_done_o,
    output logic                       ram_en_o,
    output logic [IDX_WIDTH-1:0]       ram_addr_o,
    output logic [NWAY-1:0]            tag_we_o,
    output logic [NWAY-1:0]            data_we_o,
    output logic [TAG_ENTRY_WIDTH-1:0] tag_wdata_o,
    output icache_pkg::line_t          data_wdata_o,
    output logic                       mem_req_o,
    output icache_pkg::addr_t          mem_addr_o
);

    icache_pkg::ctrl_state_t state, next_state;

    logic [IDX_WIDTH-1:0] inv_cnt;
    logic                 inv_done;
    logic                 refill_write;

    ////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////

    // Sweep the tags right out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= icache_pkg::INVALIDATE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            icache_pkg::IDLE: begin
                if (miss_i) begin
                    next_state = icache_pkg::REFILL_REQ;
                end else if (invalidate_i && !busy_i) begin
                    next_state = icache_pkg::INVALIDATE;
                end
            end
            icache_pkg::REFILL_REQ: begin
                next_state = icache_pkg::REFILL_WAIT;
            end
            icache_pkg::REFILL_WAIT: begin
                if (mem_valid_i) begin
                    next_state = icache_pkg::IDLE;
                end
            end
            icache_pkg::INVALIDATE: begin
                if (inv_done) begin
                    next_state = icache_pkg::IDLE;
                end
            end
            default: begin
                next_state = icache_pkg::IDLE;
            end
        endcase
    end

    // Invalidate index
    assign inv_done = (inv_cnt == IDX_WIDTH'(NSET - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            inv_cnt <= '0;
        end else if (state == icache_pkg::INVALIDATE && !inv_done) begin
            inv_cnt <= inv_cnt + 1'b1;
        end else begin
            inv_cnt <= '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // CPU handshake
    ////////////////////////////////////////////////////////////

    // An idle cache with nothing pending lets a sweep go first
    assign ack_o = (state == icache_pkg::IDLE) && req_i
                   && (busy_i ? hit_i : !invalidate_i);

    assign refill_done_o = (state == icache_pkg::REFILL_WAIT) && mem_valid_i;
    assign refill_write  = refill_done_o && !req_uncached_i;

    ////////////////////////////////////////////////////////////
    // RAM ports
    ////////////////////////////////////////////////////////////

    always_comb begin
        ram_en_o    = 1'b0;
        ram_addr_o  = req_addr_i[icache_pkg::OFFSET_WIDTH +: IDX_WIDTH];
        tag_we_o    = '0;
        data_we_o   = '0;
        tag_wdata_o = {1'b1, req_addr_i[icache_pkg::ADDR_WIDTH-1 -: TAG_WIDTH]};
        case (state)
            icache_pkg::IDLE: begin
                ram_en_o   = ack_o;
                ram_addr_o = addr_i[icache_pkg::OFFSET_WIDTH +: IDX_WIDTH];
            end
            icache_pkg::INVALIDATE: begin
                ram_en_o    = 1'b1;
                ram_addr_o  = inv_cnt;
                tag_we_o    = '1;
                tag_wdata_o = '0;
            end
            icache_pkg::REFILL_WAIT: begin
                ram_en_o = refill_write;
                for (int i = 0; i < NWAY; i++) begin
                    if (refill_write && victim_i == WAY_WIDTH'(i)) begin
                        tag_we_o[i]  = 1'b1;
                        data_we_o[i] = 1'b1;
                    end
                end
            end
            default: begin
            end
        endcase
    end

    assign data_wdata_o = mem_line_i;

    // Memory side
    assign mem_req_o  = (state == icache_pkg::REFILL_REQ);
    assign mem_addr_o = req_addr_i;

endmodule

//--- design/icache_top.sv
`timescale 1ns/1ps

module icache_top #(
    parameter  int NWAY            = 2,
    parameter  int NSET            = 64,
    localparam int IDX_WIDTH       = $clog2(NSET),
    localparam int TAG_WIDTH       = icache_pkg::ADDR_WIDTH - IDX_WIDTH
                                     - icache_pkg::OFFSET_WIDTH,
    localparam int TAG_ENTRY_WIDTH = TAG_WIDTH + 1,
    localparam int WAY_WIDTH       = (NWAY > 1) ? $clog2(NWAY) : 1
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_i,
    input  logic              req_uncached_i,
    input  icache_pkg::addr_t addr_i,
    output logic              ack_o,
    output logic              rvalid_o,
    output icache_pkg::line_t rdata_o,
    input  logic              invalidate_i,
    output logic              mem_req_o,
    output icache_pkg::addr_t mem_addr_o,
    input  logic              mem_valid_i,
    input  icache_pkg::line_t mem_line_i
);

    // Lookup to controller
    logic              lookup_busy;
    logic              lookup_hit;
    logic              lookup_miss;
    icache_pkg::addr_t lookup_addr;
    logic              lookup_uncached;
    logic              refill_done;
    logic [WAY_WIDTH-1:0] victim;

    // Shared RAM port, per-way write enables
    logic                                 ram_en;
    logic [IDX_WIDTH-1:0]                 ram_addr;
    logic [NWAY-1:0]                      tag_we;
    logic [NWAY-1:0]                      data_we;
    logic [TAG_ENTRY_WIDTH-1:0]           tag_wdata;
    icache_pkg::line_t                    data_wdata;
    logic [NWAY-1:0][TAG_ENTRY_WIDTH-1:0] tag_rdata;
    icache_pkg::line_t [NWAY-1:0]         data_rdata;

    generate
        for (genvar w = 0; w < NWAY; w++) begin : g_way
            icache_way_ram #(
                .WIDTH(TAG_ENTRY_WIDTH),
                .DEPTH(NSET)
            ) tag_ram_inst (
                .clk    (clk),
                .en_i   (ram_en),
                .we_i   (tag_we[w]),
                .addr_i (ram_addr),
                .wdata_i(tag_wdata),
                .rdata_o(tag_rdata[w])
            );

            icache_way_ram #(
                .WIDTH(icache_pkg::LINE_WIDTH),
                .DEPTH(NSET)
            ) data_ram_inst (
                .clk    (clk),
                .en_i   (ram_en),
                .we_i   (data_we[w]),
                .addr_i (ram_addr),
                .wdata_i(data_wdata),
                .rdata_o(data_rdata[w])
            );
        end
    endgenerate

    icache_lookup #(
        .NWAY(NWAY),
        .NSET(NSET)
    ) lookup_inst (
        .clk           (clk),
        .rst           (rst),
        .accept_i      (ack_o),
        .addr_i        (addr_i),
        .uncached_i    (req_uncached_i),
        .refill_done_i (refill_done),
        .tag_rdata_i   (tag_rdata),
        .data_rdata_i  (data_rdata),
        .mem_line_i    (mem_line_i),
        .busy_o        (lookup_busy),
        .hit_o         (lookup_hit),
        .miss_o        (lookup_miss),
        .req_addr_o    (lookup_addr),
        .req_uncached_o(lookup_uncached),
        .rvalid_o      (rvalid_o),
        .rdata_o       (rdata_o)
    );

    icache_ctrl #(
        .NWAY(NWAY),
        .NSET(NSET)
    ) ctrl_inst (
        .clk           (clk),
        .rst           (rst),
        .req_i         (req_i),
        .addr_i        (addr_i),
        .invalidate_i  (invalidate_i),
        .busy_i        (lookup_busy),
        .hit_i         (lookup_hit),
        .miss_i        (lookup_miss),
        .req_addr_i    (lookup_addr),
        .req_uncached_i(lookup_uncached),
        .victim_i      (victim),
        .mem_valid_i   (mem_valid_i),
        .mem_line_i    (mem_line_i),
        .ack_o         (ack_o),
        .refill_done_o (refill_done),
        .ram_en_o      (ram_en),
        .ram_addr_o    (ram_addr),
        .tag_we_o      (tag_we),
        .data_we_o     (data_we),
        .tag_wdata_o   (tag_wdata),
        .data_wdata_o  (data_wdata),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o)
    );

    icache_lfsr #(
        .NWAY(NWAY)
    ) lfsr_inst (
        .clk     (clk),
        .rst     (rst),
        .victim_o(victim)
    );

endmodule

//--- bench/icache_assertions.sv
`timescale 1ns/1ps

module icache_assertions (
    input logic                    clk,
    input logic                    rst,
    input icache_pkg::ctrl_state_t state_i,
    input logic                    ack_i,
    input logic                    mem_req_i,
    input logic                    mem_valid_i
);

    // Refill requested and not yet answered
    logic refill_open;

    always_ff @(posedge clk) begin
        if (rst) begin
            refill_open <= 1'b0;
        end else if (mem_req_i) begin
            refill_open <= 1'b1;
        end else if (mem_valid_i) begin
            refill_open <= 1'b0;
        end
    end

    // Refill leaves IDLE two cycles after the missing read was taken
    mem_req_state: assert property (@(posedge clk) disable iff (rst)
        mem_req_i |-> $past(ack_i, 2) && $past(state_i) == icache_pkg::IDLE)
        else $error("mem_req_o not two cycles after an accepted request");

    // No request taken while the refill is still out
    ack_state: assert property (@(posedge clk) disable iff (rst)
        ack_i |-> !refill_open)
        else $error("ack_o high while a refill was in flight");

    single_refill: assert property (@(posedge clk) disable iff (rst)
        mem_req_i |-> !refill_open)
        else $error("second mem_req_o before mem_valid_i");

endmodule

bind icache_ctrl icache_assertions ctrl_assertions_inst (
    .clk        (clk),
    .rst        (rst),
    .state_i    (state),
    .ack_i      (ack_o),
    .mem_req_i  (mem_req_o),
    .mem_valid_i(mem_valid_i)
);

//--- bench/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

    localparam int NSET      = 64;
    localparam int RUN_LIMIT = 400;
    localparam int PAIR_TRIES = 16;

    localparam icache_pkg::line_t LINE_MASK = 128'h5a5a_c3c3_0ff0_9669_a5a5_3c3c_f00f_6996;

    typedef enum {
        OP_READ,
        OP_UNCACHED,
        OP_INVAL,
        OP_PAIR
    } op_t;

    typedef struct {
        op_t               op;
        icache_pkg::addr_t addr;
        int                mem_inc;
        bit                chain;
    } entry_t;

    logic              clk;
    logic              rst;
    logic              req_i;
    logic              req_uncached_i;
    icache_pkg::addr_t addr_i;
    logic              ack_o;
    logic              rvalid_o;
    icache_pkg::line_t rdata_o;
    logic              invalidate_i;
    logic              mem_req_o;
    icache_pkg::addr_t mem_addr_o;
    logic              mem_valid_i;
    icache_pkg::line_t mem_line_i;

    entry_t            stim_q[$];
    icache_pkg::addr_t pend_addr[$];
    bit                pend_unc[$];
    int                delay_tab[64];
    int                mem_count;
    int                mem_wait;
    icache_pkg::addr_t mem_addr_seen;
    bit                sweep_pending;

    icache_top icache_top_inst (
        .clk           (clk),
        .rst           (rst),
        .req_i         (req_i),
        .req_uncached_i(req_uncached_i),
        .addr_i        (addr_i),
        .ack_o         (ack_o),
        .rvalid_o      (rvalid_o),
        .rdata_o       (rdata_o),
        .invalidate_i  (invalidate_i),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_valid_i   (mem_valid_i),
        .mem_line_i    (mem_line_i)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    // Line address repeated four times, then scrambled
    function automatic icache_pkg::line_t line_for(input icache_pkg::addr_t addr);
        icache_pkg::addr_t line_addr;
        line_addr = {addr[31:4], 4'h0};
        return {4{line_addr}} ^ LINE_MASK;
    endfunction

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Fail at %0t ns: %s is %h, expected %h",
                                     $time, name, got, exp));
        end
    endtask

    task automatic add_entry(input op_t op, input icache_pkg::addr_t addr,
                             input int mem_inc, input bit chain);
        entry_t e;
        e.op      = op;
        e.addr    = addr;
        e.mem_inc = mem_inc;
        e.chain   = chain;
        stim_q.push_back(e);
    endtask

    task automatic queue_read(input icache_pkg::addr_t addr, input bit uncached);
        pend_addr.push_back(addr);
        pend_unc.push_back(uncached);
    endtask

    task automatic drive_next();
        if (pend_addr.size() > 0) begin
            req_i          = 1'b1;
            addr_i         = pend_addr[0];
            req_uncached_i = pend_unc[0];
        end else begin
            req_i          = 1'b0;
            req_uncached_i = 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Read runner, issues queued reads and checks each response
    ////////////////////////////////////////////////////////////

    task automatic run_reads();
        icache_pkg::addr_t exp_q[$];
        icache_pkg::addr_t expected;
        int                cycles;
        cycles = 0;
        @(negedge clk);
        drive_next();
        while (pend_addr.size() > 0 || exp_q.size() > 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > RUN_LIMIT) begin
                report_failure("Timeout while waiting for a read to finish");
            end
            if (rvalid_o) begin
                if (exp_q.size() == 0) begin
                    report_failure("Read response came with no read outstanding");
                end
                expected = exp_q.pop_front();
                check_value("rdata_o", rdata_o, line_for(expected));
            end
            if (ack_o) begin
                if (sweep_pending && cycles < NSET) begin
                    report_failure("Request acknowledged before the invalidate sweep ended");
                end
                sweep_pending = 1'b0;
                exp_q.push_back(pend_addr.pop_front());
                void'(pend_unc.pop_front());
            end else if (sweep_pending) begin
                check_value("rvalid_o", rvalid_o, 1'b0);
                check_value("mem_req_o", mem_req_o, 1'b0);
            end
            @(negedge clk);
            drive_next();
        end
    endtask

    task automatic run_invalidate();
        @(negedge clk);
        invalidate_i = 1'b1;
        @(negedge clk);
        invalidate_i = 1'b0;
        sweep_pending = 1'b1;
    endtask

    // Random victims may collide, so refill until both lines sit in the set
    task automatic fill_set(input icache_pkg::addr_t addr_a);
        icache_pkg::addr_t addr_b;
        int                base;
        bit                together;
        addr_b   = addr_a + icache_pkg::addr_t'(NSET * 16);
        together = 1'b0;
        for (int attempt = 0; attempt < PAIR_TRIES && !together; attempt++) begin
            queue_read(addr_a, 1'b0);
            queue_read(addr_b, 1'b0);
            run_reads();
            base = mem_count;
            queue_read(addr_a, 1'b0);
            queue_read(addr_b, 1'b0);
            run_reads();
            together = (mem_count == base);
        end
        if (!together) begin
            report_failure("Two lines of one set never hit together");
        end
    endtask

    task automatic load_table();
        add_entry(OP_READ,     32'h0000_1000, 1, 1'b0);
        add_entry(OP_READ,     32'h0000_1000, 0, 1'b0);
        add_entry(OP_READ,     32'h0000_1008, 0, 1'b0);
        // Uncached line is fetched again when read cached
        add_entry(OP_UNCACHED, 32'h0000_2010, 1, 1'b0);
        add_entry(OP_READ,     32'h0000_2010, 1, 1'b0);
        add_entry(OP_READ,     32'h0000_201c, 0, 1'b0);
        add_entry(OP_PAIR,     32'h0000_3020, 0, 1'b0);
        add_entry(OP_READ,     32'h0000_1004, 0, 1'b0);
        add_entry(OP_READ,     32'h0000_2010, 0, 1'b0);
        add_entry(OP_INVAL,    32'h0000_0000, 0, 1'b0);
        add_entry(OP_READ,     32'h0000_1000, 1, 1'b0);
        add_entry(OP_READ,     32'h0000_2010, 1, 1'b0);
        add_entry(OP_READ,     32'h0000_3020, 1, 1'b0);
        add_entry(OP_READ,     32'h0000_3420, 1, 1'b0);
        // Back-to-back hits with req_i held
        add_entry(OP_READ,     32'h0000_1000, 0, 1'b1);
        add_entry(OP_READ,     32'h0000_2014, 0, 1'b1);
        add_entry(OP_READ,     32'h0000_100c, 0, 1'b1);
        add_entry(OP_READ,     32'h0000_201c, 0, 1'b1);
        add_entry(OP_READ,     32'h0000_1000, 0, 1'b0);
    endtask

    ////////////////////////////////////////////////////////////
    // Memory model
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst) begin
            mem_valid_i = 1'b0;
            mem_wait    = 0;
        end else begin
            mem_valid_i = 1'b0;
            if (mem_req_o) begin
                if (mem_wait != 0) begin
                    report_failure("Second memory request before the refill returned");
                end
                mem_addr_seen = mem_addr_o;
                mem_wait      = delay_tab[mem_count % 64];
                mem_count++;
            end else if (mem_wait != 0) begin
                mem_wait--;
                if (mem_wait == 0) begin
                    mem_valid_i = 1'b1;
                    mem_line_i  = line_for(mem_addr_seen);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        int i;
        int last;
        int base;
        int inc;
        clk            = 1'b0;
        rst            = 1'b1;
        req_i          = 1'b0;
        req_uncached_i = 1'b0;
        addr_i         = '0;
        invalidate_i   = 1'b0;
        mem_valid_i    = 1'b0;
        mem_line_i     = '0;
        mem_count      = 0;
        mem_wait       = 0;
        mem_addr_seen  = '0;
        void'($urandom(6083));
        for (int k = 0; k < 64; k++) begin
            delay_tab[k] = 2 + ($urandom % 8);
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst           = 1'b0;
        sweep_pending = 1'b1;
        load_table();
        i = 0;
        while (i < stim_q.size()) begin
            case (stim_q[i].op)
                OP_INVAL: begin
                    run_invalidate();
                    i++;
                end
                OP_PAIR: begin
                    fill_set(stim_q[i].addr);
                    i++;
                end
                default: begin
                    last = i;
                    while (stim_q[last].chain && last + 1 < stim_q.size()) begin
                        last++;
                    end
                    base = mem_count;
                    inc  = 0;
                    for (int k = i; k <= last; k++) begin
                        queue_read(stim_q[k].addr, stim_q[k].op == OP_UNCACHED);
                        inc += stim_q[k].mem_inc;
                    end
                    run_reads();
                    check_value("memory request count", mem_count - base, inc);
                    if (i == last && stim_q[i].mem_inc == 1) begin
                        check_value("mem_addr_o", mem_addr_seen, stim_q[i].addr);
                    end
                    i = last + 1;
                end
            endcase
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- compile.f
design/icache_pkg.sv
design/icache_way_ram.sv
design/icache_lfsr.sv
design/icache_lookup.sv
design/icache_ctrl.sv
design/icache_top.sv
bench/icache_assertions.sv
bench/icache_tb.sv

//--- Bender.yml
package:
  name: icache

sources:
  - design/icache_pkg.sv
  - design/icache_way_ram.sv
  - design/icache_lfsr.sv
  - design/icache_lookup.sv
  - design/icache_ctrl.sv
  - design/icache_top.sv
  - target: simulation
    files:
      - bench/icache_assertions.sv
      - bench/icache_tb.sv
